//--- all.f
src/bif_pkg.sv
src/cmd_queue.sv
src/bif_ctrl.sv
src/cd_lbd_xcvr.sv
src/local_store.sv
src/bif_top.sv
bench/bif_tb.sv

//--- bench/bif_tb.sv
// Testbench for bif_top with stimulus table, LCG data, reference memory, credit tracking, timeout
module bif_tb
   import bif_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int DATA_W      = BIF_DATA_W;
   localparam int ADDR_W      = BIF_ADDR_W;
   localparam int QUEUE_DEPTH = BIF_QUEUE_DEPTH;
   localparam int WORDS       = 2 ** ADDR_W;
   localparam int BURST_START = 3 + 2 * WORDS;             // Directed, writes, reads, then burst
   localparam int N_ENTRIES   = BURST_START + QUEUE_DEPTH;
   localparam int TIMEOUT     = N_ENTRIES * 4 * 2 + 100;   // Cycles after reset

   logic              clk = 1'b0;
   logic              arst_n;
   logic              cmd_valid;
   bif_op_e           cmd_op;
   logic [ADDR_W-1:0] cmd_addr;
   logic [DATA_W-1:0] cmd_data;
   logic              credit_ret;
   logic              rsp_valid;
   logic [DATA_W-1:0] rsp_data;

   bif_op_e           tbl_op    [N_ENTRIES];
   logic [ADDR_W-1:0] tbl_addr  [N_ENTRIES];
   logic [DATA_W-1:0] tbl_data  [N_ENTRIES];
   logic              tbl_rnd   [N_ENTRIES];   // Data comes from the LCG
   logic              tbl_drain [N_ENTRIES];   // Wait for all credits and responses first
   logic [DATA_W-1:0] tbl_exp   [N_ENTRIES];   // Read data from the reference memory
   logic [DATA_W-1:0] ref_mem   [WORDS];
   logic [DATA_W-1:0] exp_q     [$];           // Reads in flight, command order
   int                exp_idx_q [$];
   logic [31:0]       lcg_state = 32'h66d0_87d9;
   int                sent_cnt = 0;
   int                ret_cnt = 0;             // credit_ret pulses seen
   int                rsp_cnt = 0;
   int                cycles = 0;
   int                rsp_base = 0;            // Responses before the burst
   int                burst_reads = 0;

   bif_top #(.DATA_W(DATA_W), .ADDR_W(ADDR_W), .QUEUE_DEPTH(QUEUE_DEPTH)) bif_top_inst (
      .clk(clk), .arst_n(arst_n),
      .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
      .credit_ret(credit_ret), .rsp_valid(rsp_valid), .rsp_data(rsp_data)
   );

   always #10 clk = ~clk;                      // 20 ns period

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         $display("Finished with errors");
         $fatal(1, "Value mismatch");
      end
   endtask

   task automatic set_entry(input int idx, input bif_op_e op, input int addr, input int data,
                            input logic rnd, input logic drain);
      tbl_op[idx]    = op;
      tbl_addr[idx]  = ADDR_W'(addr);           // Wraps for narrow address widths
      tbl_data[idx]  = DATA_W'(data);
      tbl_rnd[idx]   = rnd;
      tbl_drain[idx] = drain;
   endtask

   task automatic fill_table();
      set_entry(0, OP_WRITE, 3, 32'h0000_a5c3, 1'b0, 1'b0);
      set_entry(1, OP_READ, 3, 0, 1'b0, 1'b0);                // Same address back
      set_entry(2, OP_READ, 5, 0, 1'b0, 1'b0);                // Never written, zero
      for (int k = 0; k < WORDS; k++) begin
         set_entry(3 + k, OP_WRITE, k, 0, 1'b1, 1'b0);       // Every address, random data
      end
      for (int k = 0; k < WORDS; k++) begin
         set_entry(3 + WORDS + k, OP_READ, k * 7 + 3, 0, 1'b0, 1'b0);  // Odd stride shuffle
      end
      for (int k = 0; k < QUEUE_DEPTH; k++) begin
         set_entry(BURST_START + k, (k % 2 == 1) ? OP_READ : OP_WRITE, k / 2 * 5 + 1, 0,
                   1'b1, k == 0);                             // Whole credit pool at once
      end
      for (int a = 0; a < WORDS; a++) ref_mem[a] = '0;       // Store clears at reset
      for (int k = 0; k < N_ENTRIES; k++) begin
         tbl_exp[k] = '0;
         if (tbl_rnd[k]) begin
            lcg_state   = lcg_next(lcg_state);
            tbl_data[k] = DATA_W'(lcg_state[31:16]);           // Upper bits, better spread
         end
         if (tbl_op[k] == OP_WRITE) ref_mem[tbl_addr[k]] = tbl_data[k];
         else tbl_exp[k] = ref_mem[tbl_addr[k]];
         if (tbl_op[k] == OP_READ && k >= BURST_START) burst_reads++;
      end
   endtask

   // Outputs sampled on the falling edge, away from the DUT's register updates
   always @(negedge clk) begin
      if (arst_n) begin
         cycles++;
         if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles with commands or responses still pending", cycles);
            $display("Finished with errors");
            $fatal(1, "Timeout");
         end else if (rsp_valid && exp_q.size() == 0) begin
            $display("Response arrived with no read command outstanding");
            $display("Finished with errors");
            $fatal(1, "Unexpected response");
         end else begin
            if (credit_ret) ret_cnt++;
            check_value("credit not over-returned", 32'd1, 32'(ret_cnt <= sent_cnt));
            if (rsp_valid) begin
               check_value($sformatf("read entry %0d", exp_idx_q.pop_front()),
                           32'(exp_q.pop_front()), 32'(rsp_data));
               rsp_cnt++;
            end else begin
               check_value("cd pull-up", 32'({DATA_W{1'b1}}), 32'(rsp_data));
            end
         end
      end
   end

   initial begin
      int i;
      arst_n    = 1'b0;
      cmd_valid = 1'b0;
      cmd_op    = OP_WRITE;
      cmd_addr  = '0;
      cmd_data  = '0;
      fill_table();
      repeat (8) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      check_value("reset credit_ret", 32'd0, 32'(credit_ret));
      check_value("reset rsp_valid", 32'd0, 32'(rsp_valid));
      check_value("reset rsp_data", 32'({DATA_W{1'b1}}), 32'(rsp_data));
      i = 0;
      while (i < N_ENTRIES) begin
         @(posedge clk);
         if (tbl_drain[i] && !(sent_cnt == ret_cnt && exp_q.size() == 0)) begin
            cmd_valid <= 1'b0;                               // Let the pipe empty
         end else if (sent_cnt - ret_cnt < QUEUE_DEPTH) begin
            if (i == BURST_START) rsp_base = rsp_cnt;
            cmd_valid <= 1'b1;
            cmd_op    <= tbl_op[i];
            cmd_addr  <= tbl_addr[i];
            cmd_data  <= tbl_data[i];
            if (tbl_op[i] == OP_READ) begin
               exp_q.push_back(tbl_exp[i]);
               exp_idx_q.push_back(i);
            end
            sent_cnt++;
            i++;
         end else begin
            cmd_valid <= 1'b0;                               // Out of credits
         end
      end
      @(posedge clk);
      cmd_valid <= 1'b0;
      while (exp_q.size() != 0) @(posedge clk);           // Last entry is a read
      check_value("credit pulses", 32'(N_ENTRIES), 32'(ret_cnt));
      check_value("credits restored", 32'(QUEUE_DEPTH), 32'(QUEUE_DEPTH - sent_cnt + ret_cnt));
      check_value("burst responses", 32'(burst_reads), 32'(rsp_cnt - rsp_base));
      $display("Finished with no errors");
      $finish;
   end

endmodule

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it; exit status is the simulator's
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert --top-module bif_tb -f all.f -o bif_tb_sim \
   && ./obj_dir/bif_tb_sim \
   || { echo "Simulation failed"; exit 1; }

//--- src/bif_ctrl.sv
// Control FSM popping commands and sequencing transceiver and local store strobes
module bif_ctrl
   import bif_pkg::*;
#(
   parameter int ADDR_W = BIF_ADDR_W
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              q_empty,
   input  bif_op_e           q_op,
   input  logic [ADDR_W-1:0] q_addr,
   output logic              q_pop,       // Release the head once its data is latched
   output logic              clk_ab_en,   // Latch CD into the A-to-B register
   output logic              clk_ba_en,   // Latch LBD into the B-to-A register
   output logic              dir_to_lbd,  // Stored A-to-B value onto LBD
   output logic              cd_oe,       // Transceiver drives CD
   output logic [ADDR_W-1:0] st_addr,
   output logic              st_we,       // Local store write strobe
   output logic              st_re,       // Local store read strobe
   output logic              rsp_valid    // Read data on CD this cycle
);

   bif_state_e        state;
   bif_state_e        state_nxt;
   bif_op_e           op_r;              // Operation taken from the head
   logic [ADDR_W-1:0] addr_r;            // Its address, held for the whole pass
   logic              is_wr;
   logic              is_rd;

   assign is_wr = (op_r == OP_WRITE);
   assign is_rd = (op_r == OP_READ);

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE:  if (!q_empty) state_nxt = ST_LATCH;  // Take the head command
         ST_LATCH: state_nxt = ST_XFER;
         ST_XFER:  state_nxt = ST_DONE;
         ST_DONE:  state_nxt = ST_IDLE;
         default:  state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= ST_IDLE;
         op_r  <= OP_WRITE;
      end else begin
         state <= state_nxt;
         if (state == ST_IDLE && !q_empty) op_r <= q_op;
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_IDLE && !q_empty) addr_r <= q_addr;  // Address payload
   end

   // Head entry stays valid during ST_LATCH so q_data is still on cd_in
   assign q_pop      = (state == ST_LATCH);
   assign clk_ab_en  = (state == ST_LATCH) && is_wr;  // CD data into A-to-B
   assign st_re      = (state == ST_LATCH) && is_rd;  // Store read register loads
   assign dir_to_lbd = (state == ST_XFER)  && is_wr;
   assign st_we      = (state == ST_XFER)  && is_wr;  // Stored value into the store
   assign clk_ba_en  = (state == ST_XFER)  && is_rd;  // rd_data into B-to-A
   assign cd_oe      = (state == ST_DONE)  && is_rd;
   assign rsp_valid  = (state == ST_DONE)  && is_rd;
   assign st_addr    = addr_r;

   // Both storage registers never load in the same cycle
   a_ab_ba_excl: assert property (@(posedge clk) disable iff (!arst_n)
      !(clk_ab_en && clk_ba_en))
      else $error("A-to-B and B-to-A latch enables both high");

endmodule

//--- src/bif_pkg.sv
// Operation and control state enums, default data width, address width and queue depth
package bif_pkg;

   // CPU-side operation code, carried with each queued command
   typedef enum logic {
      OP_WRITE = 1'b0,                       // CD data goes to the local store
      OP_READ  = 1'b1                        // Local store data returns on CD
   } bif_op_e;

   // Control FSM states, one command per pass through all four
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,                       // Wait for a command at the queue head
      ST_LATCH = 2'd1,                       // Latch CD or start the store read
      ST_XFER  = 2'd2,                       // Store write or B-to-A latch
      ST_DONE  = 2'd3                        // Drive CD for reads
   } bif_state_e;

   // Defaults for the module parameters, overridden from the top level
   localparam int BIF_DATA_W      = 16;      // CD and LBD width
   localparam int BIF_ADDR_W      = 4;       // Local store address bits
   localparam int BIF_QUEUE_DEPTH = 4;       // Queue entries, also the credits at reset

endpackage

//--- src/bif_top.sv
// Top level tying command queue, control FSM, transceiver and local store together
module bif_top
   import bif_pkg::*;
#(
   parameter int DATA_W      = BIF_DATA_W,
   parameter int ADDR_W      = BIF_ADDR_W,
   parameter int QUEUE_DEPTH = BIF_QUEUE_DEPTH
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              cmd_valid,   // One command per held credit
   input  bif_op_e           cmd_op,
   input  logic [ADDR_W-1:0] cmd_addr,
   input  logic [DATA_W-1:0] cmd_data,
   output logic              credit_ret,
   output logic              rsp_valid,   // Read data, in command order
   output logic [DATA_W-1:0] rsp_data     // All ones while CD is not driven
);

   logic              q_empty;
   bif_op_e           q_op;
   logic [ADDR_W-1:0] q_addr;
   logic [DATA_W-1:0] q_data;             // Head data, onto the transceiver CD input
   logic              q_pop;
   logic              clk_ab_en;
   logic              clk_ba_en;
   logic              dir_to_lbd;
   logic              cd_oe;
   logic [ADDR_W-1:0] st_addr;
   logic              st_we;
   logic              st_re;
   logic [DATA_W-1:0] lbd_out;            // Transceiver to store
   logic [DATA_W-1:0] rd_data;            // Store back to transceiver

   cmd_queue #(.DATA_W(DATA_W), .ADDR_W(ADDR_W), .QUEUE_DEPTH(QUEUE_DEPTH)) cmd_queue_inst (
      .clk(clk), .arst_n(arst_n),
      .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
      .q_pop(q_pop), .q_empty(q_empty), .q_op(q_op), .q_addr(q_addr), .q_data(q_data),
      .credit_ret(credit_ret)
   );

   bif_ctrl #(.ADDR_W(ADDR_W)) bif_ctrl_inst (
      .clk(clk), .arst_n(arst_n),
      .q_empty(q_empty), .q_op(q_op), .q_addr(q_addr), .q_pop(q_pop),
      .clk_ab_en(clk_ab_en), .clk_ba_en(clk_ba_en), .dir_to_lbd(dir_to_lbd), .cd_oe(cd_oe),
      .st_addr(st_addr), .st_we(st_we), .st_re(st_re),
      .rsp_valid(rsp_valid)
   );

   cd_lbd_xcvr #(.DATA_W(DATA_W)) cd_lbd_xcvr_inst (
      .clk(clk), .arst_n(arst_n),
      .cd_in(q_data), .lbd_in(rd_data),
      .clk_ab_en(clk_ab_en), .clk_ba_en(clk_ba_en), .dir_to_lbd(dir_to_lbd), .cd_oe(cd_oe),
      .lbd_out(lbd_out), .cd_out(rsp_data)     // CD output is the response bus
   );

   local_store #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) local_store_inst (
      .clk(clk), .arst_n(arst_n),
      .st_addr(st_addr), .st_we(st_we), .st_re(st_re),
      .wr_data(lbd_out), .rd_data(rd_data)
   );

endmodule

//--- src/cd_lbd_xcvr.sv
// Registered bidirectional CD/LBD transceiver with stored/live select and CD pull-up
module cd_lbd_xcvr
   import bif_pkg::*;
#(
   parameter int DATA_W = BIF_DATA_W
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic [DATA_W-1:0] cd_in,       // CPU data side
   input  logic [DATA_W-1:0] lbd_in,      // Local bus side
   input  logic              clk_ab_en,   // Load A-to-B register from CD
   input  logic              clk_ba_en,   // Load B-to-A register from LBD
   input  logic              dir_to_lbd,  // Stored or live select towards LBD
   input  logic              cd_oe,       // CD output enable
   output logic [DATA_W-1:0] lbd_out,
   output logic [DATA_W-1:0] cd_out
);

   logic [DATA_W-1:0] ab_reg;             // CD to LBD storage register
   logic [DATA_W-1:0] ba_reg;             // LBD to CD storage register

   // One clock stands in for the two 74646 strobes, enables pick the register
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ab_reg <= '0;
         ba_reg <= '0;
      end else begin
         if (clk_ab_en) ab_reg <= cd_in;
         if (clk_ba_en) ba_reg <= lbd_in;
      end
   end

   // LBD side, stored A-to-B while writing, otherwise live CD
   assign lbd_out = dir_to_lbd ? ab_reg : cd_in;

   // CD side is pulled high while the transceiver is not driving it
   assign cd_out = cd_oe ? ba_reg : '1;

endmodule

//--- src/cmd_queue.sv
// Credit-guarded command FIFO with credit return and overflow/underflow assertions
module cmd_queue
   import bif_pkg::*;
#(
   parameter int DATA_W      = BIF_DATA_W,
   parameter int ADDR_W      = BIF_ADDR_W,
   parameter int QUEUE_DEPTH = BIF_QUEUE_DEPTH  // Power of two, at least 2
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              cmd_valid,       // Push, only sent while holding a credit
   input  bif_op_e           cmd_op,
   input  logic [ADDR_W-1:0] cmd_addr,
   input  logic [DATA_W-1:0] cmd_data,
   input  logic              q_pop,           // Release the head entry
   output logic              q_empty,
   output bif_op_e           q_op,
   output logic [ADDR_W-1:0] q_addr,
   output logic [DATA_W-1:0] q_data,
   output logic              credit_ret       // One pulse per released entry
);

   localparam int PTR_W = $clog2(QUEUE_DEPTH);
   localparam int CNT_W = PTR_W + 1;

   bif_op_e           op_mem   [QUEUE_DEPTH];  // Entry storage, no reset needed
   logic [ADDR_W-1:0] addr_mem [QUEUE_DEPTH];
   logic [DATA_W-1:0] data_mem [QUEUE_DEPTH];

   logic [PTR_W-1:0] wr_ptr;                   // Wraps naturally, depth is 2**PTR_W
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;                    // Occupancy, 0 to QUEUE_DEPTH
   logic             q_full;

   assign q_empty = (count == '0);
   assign q_full  = (count == CNT_W'(QUEUE_DEPTH));

   // Head is read straight from storage, visible right after the push edge
   assign q_op   = op_mem[rd_ptr];
   assign q_addr = addr_mem[rd_ptr];
   assign q_data = data_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (cmd_valid) begin
         op_mem[wr_ptr]   <= cmd_op;           // Payload write
         addr_mem[wr_ptr] <= cmd_addr;
         data_mem[wr_ptr] <= cmd_data;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         credit_ret <= 1'b0;
      end else begin
         if (cmd_valid) wr_ptr <= wr_ptr + 1'b1;
         if (q_pop)     rd_ptr <= rd_ptr + 1'b1;
         case ({cmd_valid, q_pop})
            2'b10:   count <= count + 1'b1;   // Push only
            2'b01:   count <= count - 1'b1;   // Pop only
            default: count <= count;          // Both or neither
         endcase
         credit_ret <= q_pop;                 // Freed slot goes back to the sender
      end
   end

   // The sender's credit count must keep it from overrunning the queue
   a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
      !(cmd_valid && q_full))
      else $error("Command received while queue full");

   // The control FSM must only release an entry it has seen
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
      q_pop |-> !q_empty)
      else $error("Pop while queue empty");

endmodule

//--- src/local_store.sv
// LBD-side register file with strobed write and registered read
module local_store
   import bif_pkg::*;
#(
   parameter int DATA_W = BIF_DATA_W,
   parameter int ADDR_W = BIF_ADDR_W
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic [ADDR_W-1:0] st_addr,
   input  logic              st_we,      // Write wr_data at st_addr
   input  logic              st_re,      // Load read register from st_addr
   input  logic [DATA_W-1:0] wr_data,    // From the transceiver LBD output
   output logic [DATA_W-1:0] rd_data     // Valid the cycle after st_re
);

   localparam int WORDS = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem [WORDS];
   logic [DATA_W-1:0] rd_q;

   // Unwritten words read back as zero
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < WORDS; i++) begin
            mem[i] <= '0;
         end
         rd_q <= '0;
      end else begin
         if (st_we) mem[st_addr] <= wr_data;
         if (st_re) rd_q <= mem[st_addr];   // Holds until the next read
      end
   end

   assign rd_data = rd_q;

endmodule
